//--- rv_decode.f
common/rv_decode_pkg.sv
decode/reg_file.sv
decode/imm_extend.sv
decode/decode_stage.sv
hdl/main_decoder.sv
hdl/decode_top.sv
verif/decode_assertions.sv
verif/decode_tb.sv

//--- verif/decode_tb.sv
module decode_tb import rv_decode_pkg::*; ();

    localparam int REG_COUNT     = 32;
    localparam int RESET_TIMEOUT = 20;
    localparam int PHASE_LEN     = 300;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    fetch_pkt_t  fetch_i;
    logic        stall_i;
    logic        flush_i;
    wb_pkt_t     wb_i;
    decode_pkt_t dec_o;
    ctrl_t       ctrl_o;

    integer      seed = 32'h924a567a;
    fetch_pkt_t  m_fetch;           // model of the pipeline register.
    logic [31:0] m_regs [32];
    int          phase_cycles;
    int          phase_limit;

    decode_top #(
        .REG_COUNT(REG_COUNT)
    ) decode_top_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .fetch_i (fetch_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .wb_i    (wb_i),
        .dec_o   (dec_o),
        .ctrl_o  (ctrl_o)
    );

    always #2 clk_i = ~clk_i;

    initial begin
        rst_n_i = 1'b0;
        fetch_i = '0;
        stall_i = 1'b0;
        flush_i = 1'b0;
        wb_i    = '0;
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
    end

    // ####################
    // reference model
    // ####################
    function automatic ctrl_t model_ctrl(input logic [31:0] w);
        ctrl_t      c;
        logic [2:0] f3;
        logic [2:0] arith;
        logic       f3_legal;
        f3       = w[14:12];
        f3_legal = (f3 == 3'b000) || (f3 == 3'b010) || (f3 == 3'b110) || (f3 == 3'b111);
        arith    = (f3 == 3'b010) ? ALU_SLT : (f3 == 3'b110) ? ALU_OR :
                   (f3 == 3'b111) ? ALU_AND : ALU_ADD;
        c = '0;
        if (w[6:0] == OP_LOAD && f3 == 3'b010) begin
            c.reg_write  = 1'b1;
            c.alu_src    = 1'b1;
            c.result_src = RES_MEM;
        end else if (w[6:0] == OP_STORE && f3 == 3'b010) begin
            c.mem_write = 1'b1;
            c.alu_src   = 1'b1;
        end else if (w[6:0] == OP_RTYPE && f3_legal) begin
            c.reg_write = 1'b1;
            c.alu_ctrl  = (f3 == 3'b000 && w[30]) ? ALU_SUB : arith;
        end else if (w[6:0] == OP_ITYPE && f3_legal) begin
            c.reg_write = 1'b1;
            c.alu_src   = 1'b1;
            c.alu_ctrl  = arith;
        end else if (w[6:0] == OP_BRANCH && f3 == 3'b000) begin
            c.branch   = 1'b1;
            c.alu_ctrl = ALU_SUB;
        end else if (w[6:0] == OP_JAL) begin
            c.reg_write  = 1'b1;
            c.jump       = 1'b1;
            c.result_src = RES_PC4;
        end else begin
            c.illegal = 1'b1;
        end
        return c;
    endfunction

    function automatic logic [31:0] model_imm(input logic [31:0] w);
        ctrl_t c;
        c = model_ctrl(w);
        if (!c.illegal && w[6:0] == OP_STORE) begin
            return {{20{w[31]}}, w[31:25], w[11:7]};
        end else if (!c.illegal && w[6:0] == OP_BRANCH) begin
            return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end else if (!c.illegal && w[6:0] == OP_JAL) begin
            return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        return {{20{w[31]}}, w[31:20]};     // I format, also for illegal words.
    endfunction

    function automatic logic [31:0] model_read(input logic [4:0] rs);
        if (rs == 5'd0 || rs >= REG_COUNT) begin
            return '0;
        end
        if (wb_i.reg_write && wb_i.rd == rs) begin
            return wb_i.result;             // same-cycle write.
        end
        return m_regs[rs];
    endfunction

    function automatic decode_pkt_t model_dec();
        decode_pkt_t d;
        logic [31:0] w;
        w           = m_fetch.instr;
        d.rd1       = model_read(w[19:15]);
        d.rd2       = model_read(w[24:20]);
        d.pc        = m_fetch.pc;
        d.imm_ext   = model_imm(w);
        d.pc_plus_4 = m_fetch.pc_plus_4;
        d.rs1       = w[19:15];
        d.rs2       = w[24:20];
        d.rd        = w[11:7];
        d.funct3    = w[14:12];
        d.op        = w[6:0];
        d.funct7_b5 = w[30];
        return d;
    endfunction

    // applies the inputs seen at this rising edge.
    task automatic update_model();
        if (!rst_n_i) begin
            m_fetch = '0;
            for (int i = 0; i < 32; i++) begin
                m_regs[i] = '0;
            end
        end else begin
            if (wb_i.reg_write && wb_i.rd != 5'd0 && wb_i.rd < REG_COUNT) begin
                m_regs[wb_i.rd] = wb_i.result;
            end
            if (flush_i) begin
                m_fetch = '0;
            end else if (!stall_i) begin
                m_fetch = fetch_i;
            end
        end
    endtask

    // ####################
    // stimulus
    // ####################
    function automatic bit chance(input int pct);
        return ({$random(seed)} % 100) < pct;
    endfunction

    function automatic fetch_pkt_t random_fetch();
        fetch_pkt_t  f;
        logic [31:0] w;
        int          pick;
        w    = $random(seed);
        pick = {$random(seed)} % 6;
        if (chance(80)) begin
            case (pick)
                0: w[6:0] = OP_LOAD;
                1: w[6:0] = OP_STORE;
                2: w[6:0] = OP_RTYPE;
                3: w[6:0] = OP_ITYPE;
                4: w[6:0] = OP_BRANCH;
                default: w[6:0] = OP_JAL;
            endcase
            if (chance(90)) begin
                case (w[6:0])
                    OP_LOAD, OP_STORE: w[14:12] = 3'b010;
                    OP_BRANCH: w[14:12] = 3'b000;
                    // maps to 000, 010, 110 or 111.
                    OP_RTYPE, OP_ITYPE: w[14:12] = {w[13], w[13] | w[12], w[13] & w[12]};
                    default: ;
                endcase
            end
        end
        f.instr     = w;
        f.pc        = $random(seed);
        f.pc[1:0]   = 2'b00;
        f.pc_plus_4 = f.pc + 32'd4;
        return f;
    endfunction

    function automatic wb_pkt_t random_wb(input logic [4:0] held_rs1);
        wb_pkt_t     wb;
        logic [31:0] r;
        r            = $random(seed);
        wb.reg_write = r[0];
        wb.rd        = chance(25) ? held_rs1 : r[5:1];
        wb.result    = $random(seed);
        return wb;
    endfunction

    // ####################
    // checking
    // ####################
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_dec(input string name, input decode_pkt_t exp, input decode_pkt_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            stop_with_failure("decode packet mismatch");
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            stop_with_failure("control word mismatch");
        end
    endtask

    task automatic next_edge();
        @(posedge clk_i);
        update_model();
        phase_cycles++;
        if (phase_cycles > phase_limit) begin
            stop_with_failure("stimulus phase ran past its cycle budget");
        end
    endtask

    task automatic check_outputs(input string name);
        @(negedge clk_i);
        check_dec(name, model_dec(), dec_o);
        check_ctrl(name, model_ctrl(m_fetch.instr), ctrl_o);
        if (decode_top_i.decode_assertions_i.fail_cnt != 0) begin
            stop_with_failure("an assertion bound to decode_top fired");
        end
    endtask

    initial begin
        fetch_pkt_t f;
        ctrl_t      only_illegal;
        int         waited;
        m_fetch = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        only_illegal         = '0;
        only_illegal.illegal = 1'b1;

        waited = 0;
        while (rst_n_i !== 1'b1) begin
            @(posedge clk_i);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                stop_with_failure("reset was never released");
            end
        end
        update_model();
        @(negedge clk_i);
        check_ctrl("reset_ctrl", only_illegal, ctrl_o);
        check_dec("reset_dec", model_dec(), dec_o);

        // walk all registers, none written yet.
        phase_cycles = 0;
        phase_limit  = REG_COUNT + 4;
        for (int i = 0; i < REG_COUNT; i++) begin
            next_edge();
            f       = '0;
            f.instr = {7'd0, 5'(REG_COUNT - 1 - i), 5'(i), 3'b000, 5'd1, OP_RTYPE};
            fetch_i <= f;
            wb_i    <= '0;
            check_outputs("reset_regs");
        end

        phase_cycles = 0;
        phase_limit  = PHASE_LEN + 4;
        for (int n = 0; n < PHASE_LEN; n++) begin
            next_edge();
            fetch_i <= random_fetch();
            wb_i    <= random_wb(m_fetch.instr[19:15]);
            check_outputs("random_decode");
        end

        phase_cycles = 0;
        phase_limit  = PHASE_LEN + 4;
        for (int n = 0; n < PHASE_LEN; n++) begin
            next_edge();
            fetch_i <= random_fetch();
            stall_i <= chance(30);
            flush_i <= chance(15);          // sometimes together with stall.
            wb_i    <= random_wb(m_fetch.instr[19:15]);
            check_outputs("stall_flush");
        end

        if (decode_top_i.decode_assertions_i.fail_cnt != 0) begin
            stop_with_failure("an assertion bound to decode_top fired");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- verif/decode_assertions.sv
module decode_assertions import rv_decode_pkg::*; (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        stall_i,
    input logic        flush_i,
    input decode_pkt_t dec_i,
    input ctrl_t       ctrl_i
);

    int fail_cnt = 0;

    // a flushed slot holds the zero word, which has no side effects.
    flush_kills_ctrl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !(ctrl_i.reg_write || ctrl_i.mem_write || ctrl_i.branch || ctrl_i.jump))
    else begin
        fail_cnt++;
        $error("control still active one cycle after a flush");
    end

    x0_reads_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (dec_i.rs1 == 5'd0) |-> (dec_i.rd1 == '0))
    else begin
        fail_cnt++;
        $error("rd1 is not zero while rs1 selects x0");
    end

    stall_holds_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (stall_i && !flush_i) |=> $stable(dec_i.pc))
    else begin
        fail_cnt++;
        $error("dec pc moved during a stall");
    end

endmodule

bind decode_top decode_assertions decode_assertions_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .stall_i (stall_i),
    .flush_i (flush_i),
    .dec_i   (dec_o),
    .ctrl_i  (ctrl_o)
);

//--- hdl/decode_top.sv
module decode_top import rv_decode_pkg::*; #(
    parameter int REG_COUNT = 32    // 16 for rv32e.
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  fetch_pkt_t  fetch_i,
    input  logic        stall_i,
    input  logic        flush_i,
    input  wb_pkt_t     wb_i,
    output decode_pkt_t dec_o,
    output ctrl_t       ctrl_o
);

    logic [1:0] imm_src;

    // ####################
    // datapath
    // ####################
    decode_stage #(
        .REG_COUNT(REG_COUNT)
    ) decode_stage_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .fetch_i   (fetch_i),
        .stall_i   (stall_i),
        .flush_i   (flush_i),
        .wb_i      (wb_i),
        .imm_src_i (imm_src),
        .dec_o     (dec_o)
    );

    // ####################
    // control
    // ####################
    // decoder works on the registered fields, so control lines up with dec_o.
    main_decoder main_decoder_i (
        .op_i        (dec_o.op),
        .funct3_i    (dec_o.funct3),
        .funct7_b5_i (dec_o.funct7_b5),
        .ctrl_o      (ctrl_o),
        .imm_src_o   (imm_src)
    );

endmodule

//--- hdl/main_decoder.sv
module main_decoder import rv_decode_pkg::*; (
    input  logic [6:0] op_i,
    input  logic [2:0] funct3_i,
    input  logic       funct7_b5_i,
    output ctrl_t      ctrl_o,
    output logic [1:0] imm_src_o
);

    logic       sub_en;
    logic       f3_ok;
    logic [2:0] alu_arith;
    logic       legal;

    // only register-register add uses funct7 to pick subtract.
    assign sub_en = funct7_b5_i && (op_i == OP_RTYPE);

    // shared funct3 table of R-type and I-type.
    always_comb begin
        f3_ok = 1'b1;
        case (funct3_i)
            3'b000: alu_arith = sub_en ? ALU_SUB : ALU_ADD;
            3'b010: alu_arith = ALU_SLT;
            3'b110: alu_arith = ALU_OR;
            3'b111: alu_arith = ALU_AND;
            default: begin
                alu_arith = ALU_ADD;
                f3_ok     = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl_o    = '0;
        imm_src_o = IMM_I;
        legal     = 1'b1;
        case (op_i)
            OP_LOAD: begin
                legal             = (funct3_i == 3'b010);   // lw only.
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.result_src = RES_MEM;
                ctrl_o.alu_ctrl   = ALU_ADD;
            end
            OP_STORE: begin
                legal           = (funct3_i == 3'b010);     // sw only.
                ctrl_o.mem_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.alu_ctrl  = ALU_ADD;
                imm_src_o        = IMM_S;
            end
            OP_RTYPE: begin
                legal            = f3_ok;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_ctrl  = alu_arith;
            end
            OP_ITYPE: begin
                legal            = f3_ok;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.alu_ctrl  = alu_arith;
            end
            OP_BRANCH: begin
                legal           = (funct3_i == 3'b000);     // beq only.
                ctrl_o.branch   = 1'b1;
                ctrl_o.alu_ctrl = ALU_SUB;
                imm_src_o       = IMM_B;
            end
            OP_JAL: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.jump       = 1'b1;
                ctrl_o.result_src = RES_PC4;
                ctrl_o.alu_ctrl   = ALU_ADD;
                imm_src_o         = IMM_J;
            end
            default: begin
                legal = 1'b0;
            end
        endcase

        // an unsupported word must not write anything.
        if (!legal) begin
            ctrl_o         = '0;
            ctrl_o.illegal = 1'b1;
            imm_src_o      = IMM_I;
        end
    end

endmodule

//--- decode/decode_stage.sv
module decode_stage import rv_decode_pkg::*; #(
    parameter int REG_COUNT = 32
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  fetch_pkt_t  fetch_i,
    input  logic        stall_i,
    input  logic        flush_i,
    input  wb_pkt_t     wb_i,
    input  logic [1:0]  imm_src_i,
    output decode_pkt_t dec_o
);

    fetch_pkt_t  fetch_q;
    instr_u      instr_d;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] imm_ext;

    // ####################
    // pipeline register
    // ####################
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            fetch_q <= '0;              // flush wins over stall.
        end else if (!stall_i) begin
            fetch_q <= fetch_i;
        end
    end

    assign instr_d.raw = fetch_q.instr;

    // ####################
    // operands
    // ####################
    reg_file #(
        .REG_COUNT(REG_COUNT)
    ) reg_file_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rs1_i   (instr_d.f.rs1),
        .rs2_i   (instr_d.f.rs2),
        .wb_i    (wb_i),
        .rd1_o   (rd1),
        .rd2_o   (rd2)
    );

    imm_extend imm_extend_i (
        .instr_i   (instr_d.raw[31:7]),
        .imm_src_i (imm_src_i),
        .imm_ext_o (imm_ext)
    );

    // ####################
    // output packet
    // ####################
    always_comb begin
        dec_o.rd1       = rd1;
        dec_o.rd2       = rd2;
        dec_o.pc        = fetch_q.pc;
        dec_o.imm_ext   = imm_ext;
        dec_o.pc_plus_4 = fetch_q.pc_plus_4;
        dec_o.rs1       = instr_d.f.rs1;
        dec_o.rs2       = instr_d.f.rs2;
        dec_o.rd        = instr_d.f.rd;
        dec_o.funct3    = instr_d.f.funct3;
        dec_o.op        = instr_d.f.opcode;
        dec_o.funct7_b5 = instr_d.f.funct7[5];  // sub and sra select.
    end

endmodule

//--- decode/imm_extend.sv
module imm_extend import rv_decode_pkg::*; (
    input  logic [24:0] instr_i,    // instruction bits 31 down to 7.
    input  logic [1:0]  imm_src_i,
    output logic [31:0] imm_ext_o
);

    logic sign;

    assign sign = instr_i[24];

    // bit positions below are offset by 7 from the full word.
    always_comb begin
        case (imm_src_i)
            IMM_I: begin
                imm_ext_o = {{20{sign}}, instr_i[24:13]};
            end
            IMM_S: begin
                imm_ext_o = {{20{sign}}, instr_i[24:18], instr_i[4:0]};
            end
            IMM_B: begin
                // imm[12|10:5] at 31:25, imm[4:1|11] at 11:7.
                imm_ext_o = {
                    {20{sign}},
                    instr_i[0],
                    instr_i[23:18],
                    instr_i[4:1],
                    1'b0
                };
            end
            IMM_J: begin
                // imm[20|10:1|11|19:12] at 31:12.
                imm_ext_o = {
                    {12{sign}},
                    instr_i[12:5],
                    instr_i[13],
                    instr_i[23:14],
                    1'b0
                };
            end
            default: begin
                imm_ext_o = '0;
            end
        endcase
    end

endmodule

//--- decode/reg_file.sv
module reg_file import rv_decode_pkg::*; #(
    parameter int REG_COUNT = 32
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    input  wb_pkt_t     wb_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o
);

    localparam int IDX_W = $clog2(REG_COUNT);

    logic [31:0] regs [REG_COUNT];
    logic        wr_hit;

    // x0 and unimplemented registers never take a write.
    assign wr_hit = wb_i.reg_write && (wb_i.rd != 5'd0) && (wb_i.rd < REG_COUNT);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[wb_i.rd[IDX_W-1:0]] <= wb_i.result;
        end
    end

    function automatic logic [31:0] read_port(input logic [4:0] rs);
        logic [31:0] data;
        if ((rs == 5'd0) || (rs >= REG_COUNT)) begin
            data = '0;
        end else if (wr_hit && (wb_i.rd == rs)) begin
            data = wb_i.result;                 // write-through.
        end else begin
            data = regs[rs[IDX_W-1:0]];
        end
        return data;
    endfunction

    // re-evaluates on the register array and the write port too.
    always_comb begin
        rd1_o = read_port(rs1_i);
        rd2_o = read_port(rs2_i);
    end

endmodule

//--- common/rv_decode_pkg.sv
package rv_decode_pkg;

    // ####################
    // opcodes of the supported subset.
    // ####################
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // immediate formats.
    localparam logic [1:0] IMM_I = 2'b00;
    localparam logic [1:0] IMM_S = 2'b01;
    localparam logic [1:0] IMM_B = 2'b10;
    localparam logic [1:0] IMM_J = 2'b11;

    // alu operations, encoded as the execute stage expects.
    localparam logic [2:0] ALU_ADD = 3'b000;
    localparam logic [2:0] ALU_SUB = 3'b001;
    localparam logic [2:0] ALU_AND = 3'b010;
    localparam logic [2:0] ALU_OR  = 3'b011;
    localparam logic [2:0] ALU_SLT = 3'b101;

    // writeback result mux select.
    localparam logic [1:0] RES_ALU = 2'b00;
    localparam logic [1:0] RES_MEM = 2'b01;
    localparam logic [1:0] RES_PC4 = 2'b10;

    // ####################
    // instruction word views.
    // ####################
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

    typedef union packed {
        logic [31:0]   raw;
        instr_fields_t f;
    } instr_u;

    // ####################
    // pipeline packets.
    // ####################
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] pc_plus_4;
    } fetch_pkt_t;

    typedef struct packed {
        logic        reg_write; // write strobe, one cycle.
        logic [4:0]  rd;
        logic [31:0] result;
    } wb_pkt_t;

    typedef struct packed {
        logic       reg_write;
        logic       mem_write;
        logic       branch;
        logic       jump;
        logic       alu_src;    // 1 selects the immediate.
        logic       illegal;
        logic [1:0] result_src;
        logic [2:0] alu_ctrl;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [31:0] pc;
        logic [31:0] imm_ext;
        logic [31:0] pc_plus_4;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        logic [6:0]  op;
        logic        funct7_b5;
    } decode_pkt_t;

endpackage
